/* compile.f */
hw/rda_cfg_pkg.sv
hw/rda_types_pkg.sv
hw/rda_align_if.sv
hw/rda_fifo.sv
hw/rda_word_sequencer.sv
hw/rda_shift_stage.sv
hw/rda_word_assembler.sv
hw/rda_top.sv
sim/tb_clock_gen.sv
sim/rda_props.sv
sim/tb_rda_top.sv

/* Bender.yml */
package:
  name: rda_align

sources:
  - files:
      - hw/rda_cfg_pkg.sv
      - hw/rda_types_pkg.sv
      - hw/rda_align_if.sv
      - hw/rda_fifo.sv
      - hw/rda_word_sequencer.sv
      - hw/rda_shift_stage.sv
      - hw/rda_word_assembler.sv
      - hw/rda_top.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/rda_props.sv
      - sim/tb_rda_top.sv

/* sim/tb_rda_top.sv */
/*
 * testbench for rda_top with the default sizes, inputs change on the falling edge
 * every test stays within the data FIFO depth and drains before the next one starts
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rda_top import rda_cfg_pkg::*; ();

    localparam int MEM_B   = DEF_MEM_BYTES;
    localparam int KER_B   = DEF_KER_BYTES;
    localparam int INTRA_W = DEF_INTRA_W;
    localparam int N_ZERO  = 8;
    localparam int N_SOLE  = 12;
    localparam int N_SPLIT = 10;    // two memory words each
    localparam int N_STALL = 31;    // enough to back up the command FIFO behind a full output
    localparam int TOTAL_WORDS  = N_ZERO + N_SOLE + N_SPLIT + N_STALL;
    localparam int LIMIT_CYCLES = TOTAL_WORDS * (DEF_SHIFT_W + 20) + 16 + 200;

    logic               clock;
    logic               aclrn;
    logic               i_mem_valid;
    logic [8*MEM_B-1:0] i_mem_data;
    logic               i_cmd_valid;
    logic [INTRA_W-1:0] i_cmd_addr;
    logic               o_cmd_almost_full;
    logic               o_valid;
    logic [8*KER_B-1:0] o_data;
    logic               i_stall;

    logic [8*KER_B-1:0] exp_q [$];    // kernel words in the order they must leave
    logic [8*KER_B-1:0] cmp_word;
    logic [15:0]        data_lfsr;
    logic [15:0]        stall_lfsr;
    logic               stall_en;
    logic               hold_stall;    // keeps i_stall high until commands back up
    logic               af_seen;
    int                 pass_cnt = 0;
    int                 fail_cnt = 0;
    int                 test_fail_base = 0;
    int                 prop_fails;
    string              cur_test = "reset";

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(16)) u_clock_gen (.clock(clock), .aclrn(aclrn));

    rda_top #(
        .MEM_BYTES(DEF_MEM_BYTES), .KER_BYTES(DEF_KER_BYTES), .ALIGN_BITS(DEF_ALIGN_BITS),
        .MEM_FIFO_DEPTH(DEF_MEM_FIFO_DEPTH), .CMD_FIFO_DEPTH(DEF_CMD_FIFO_DEPTH),
        .OUT_FIFO_DEPTH(DEF_OUT_FIFO_DEPTH)
    ) u_rda_top (
        .clock(clock), .aclrn(aclrn),
        .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data),
        .i_cmd_valid(i_cmd_valid), .i_cmd_addr(i_cmd_addr),
        .o_cmd_almost_full(o_cmd_almost_full),
        .o_valid(o_valid), .o_data(o_data), .i_stall(i_stall)
    );

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////
    // galois form of x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            data_lfsr = lfsr_next(data_lfsr);    // one step per bit taken
            v[b]      = data_lfsr[0];
        end
        return v;
    endfunction

    // kernel byte i is stream byte addr+i, where the stream is w0 followed by w1
    function automatic logic [8*KER_B-1:0] expect_word(input int addr,
            input logic [8*MEM_B-1:0] w0, input logic [8*MEM_B-1:0] w1);
        logic [16*MEM_B-1:0] stream;
        logic [8*KER_B-1:0]  word;
        stream = {w1, w0};
        for (int i = 0; i < KER_B; i++) word[8*i +: 8] = stream[8*(addr+i) +: 8];
        return word;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus helpers, entered and left on a falling edge
    ////////////////////////////////////////////////////////////
    task automatic send_command(input int addr);
        logic [8*MEM_B-1:0] w0;
        logic [8*MEM_B-1:0] w1;
        logic               two;
        two = (addr + KER_B) > MEM_B;    // the kernel word runs into the next memory word
        w0  = take_bits(8*MEM_B);
        w1  = two ? take_bits(8*MEM_B) : '0;
        while (o_cmd_almost_full) begin
            af_seen    = 1'b1;
            hold_stall = 1'b0;    // let the output drain so commands move again
            @(negedge clock);
        end
        exp_q.push_back(expect_word(addr, w0, w1));
        i_cmd_valid = 1'b1;
        i_cmd_addr  = INTRA_W'(addr);
        i_mem_valid = 1'b1;
        i_mem_data  = w0;
        @(negedge clock);
        i_cmd_valid = 1'b0;
        if (two) begin
            i_mem_data = w1;
            @(negedge clock);
        end
        i_mem_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clock);
        repeat (4) @(negedge clock);    // room for a stray extra word to show up
    endtask

    task automatic report_test();
        $display("test %-6s done, %0d errors", cur_test, fail_cnt - test_fail_base);
        test_fail_base = fail_cnt;
    endtask

    // the stall for the next rising edge is set first and the transfer at that edge
    // is judged against it, o_valid and o_data hold steady from one rising edge to the next
    always @(negedge clock) begin
        if (!stall_en) begin
            i_stall = 1'b0;
        end else if (hold_stall) begin
            i_stall = 1'b1;
        end else begin
            stall_lfsr = lfsr_next(stall_lfsr);
            i_stall    = stall_lfsr[0];
        end
        if (aclrn && o_valid && !i_stall) begin
            if (exp_q.size() == 0) begin
                $display("kernel word %h came out with none expected", o_data);
                fail_cnt++;
            end else begin
                cmp_word = exp_q.pop_front();
                if (o_data !== cmp_word) begin
                    $display("MISMATCH o_data: expected %h, got %h", cmp_word, o_data);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clock);
        $display("timeout, test %s did not finish within %0d cycles", cur_test, LIMIT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        i_mem_valid = 1'b0;
        i_mem_data  = '0;
        i_cmd_valid = 1'b0;
        i_cmd_addr  = '0;
        i_stall     = 1'b0;
        stall_en    = 1'b0;
        hold_stall  = 1'b0;
        af_seen     = 1'b0;
        data_lfsr   = 16'd63;
        stall_lfsr  = 16'd63;
        @(posedge aclrn);
        @(negedge clock);
        if (o_valid !== 1'b0) begin
            $display("MISMATCH o_valid: expected %h, got %h", 1'b0, o_valid);
            fail_cnt++;
        end else pass_cnt++;
        if (o_cmd_almost_full !== 1'b0) begin
            $display("MISMATCH o_cmd_almost_full: expected %h, got %h", 1'b0, o_cmd_almost_full);
            fail_cnt++;
        end else pass_cnt++;
        report_test();

        cur_test = "addr0";
        for (int n = 0; n < N_ZERO; n++) send_command(0);
        wait_drain();
        report_test();

        cur_test = "sole";
        for (int n = 0; n < N_SOLE; n++) begin
            send_command(int'(take_bits(INTRA_W) % (MEM_B - KER_B + 1)));
        end
        wait_drain();
        report_test();

        cur_test = "split";
        for (int n = 0; n < N_SPLIT; n++) begin
            send_command(MEM_B - KER_B + 1 + int'(take_bits(2) % (KER_B - 1)));
        end
        wait_drain();
        report_test();

        cur_test = "stall";
        stall_en   = 1'b1;
        hold_stall = 1'b1;
        for (int n = 0; n < N_STALL; n++) begin
            send_command(int'(take_bits(INTRA_W) % (MEM_B - KER_B + 1)));
        end
        hold_stall = 1'b0;
        wait_drain();
        stall_en = 1'b0;
        if (!af_seen) begin
            $display("o_cmd_almost_full never rose while the output was stalled");
            fail_cnt++;
        end else pass_cnt++;
        if (o_cmd_almost_full !== 1'b0) begin
            $display("MISMATCH o_cmd_almost_full: expected %h, got %h", 1'b0, o_cmd_almost_full);
            fail_cnt++;
        end else pass_cnt++;
        report_test();

        prop_fails = u_rda_top.u_mem_fifo.u_props.fire_count
                   + u_rda_top.u_cmd_fifo.u_props.fire_count
                   + u_rda_top.u_out_fifo.u_props.fire_count
                   + u_rda_top.u_assembler.u_props.fire_count;
        $display("checks passed %0d, failed %0d, assertion failures %0d",
                 pass_cnt, fail_cnt, prop_fails);
        if (fail_cnt == 0 && prop_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rda_props.sv */
/*
 * assertions bound into every rda_fifo and into the word assembler
 * each bound copy keeps its own fire_count of failed assertions
 */
`timescale 1ns/1ps
`default_nettype none

module rda_props import rda_types_pkg::*; (
    input wire       clock,
    input wire       aclrn,
    input wire       i_wr,
    input wire       i_rd,
    input wire       i_empty,
    input wire       i_full,
    input wire       i_beat_valid,
    input var beat_e i_beat_kind
);

    int   fire_count = 0;
    logic head_pending;    // the last beat seen was a head

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn)            head_pending <= 1'b0;
        else if (i_beat_valid) head_pending <= (i_beat_kind == BEAT_HEAD);
    end

    no_write_when_full: assert property (@(posedge clock) disable iff (!aclrn) i_wr |-> !i_full)
        else begin
            fire_count++;
            $error("write into a full FIFO");
        end

    no_read_when_empty: assert property (@(posedge clock) disable iff (!aclrn) i_rd |-> !i_empty)
        else begin
            fire_count++;
            $error("read from an empty FIFO");
        end

    // the beat that follows a head must close the kernel word
    tail_after_head: assert property (@(posedge clock) disable iff (!aclrn)
        (i_beat_valid && head_pending) |-> (i_beat_kind == BEAT_TAIL))
        else begin
            fire_count++;
            $error("beat after a head beat is not a tail beat");
        end

endmodule

bind rda_fifo rda_props u_props (
    .clock(clock), .aclrn(aclrn), .i_wr(i_wr), .i_rd(i_rd), .i_empty(o_empty),
    .i_full(count == DEPTH), .i_beat_valid(1'b0), .i_beat_kind(rda_types_pkg::BEAT_SOLE)
);

bind rda_word_assembler rda_props u_props (
    .clock(clock), .aclrn(aclrn), .i_wr(1'b0), .i_rd(1'b0), .i_empty(1'b0), .i_full(1'b0),
    .i_beat_valid(i_beat.valid), .i_beat_kind(i_beat.kind)
);

`default_nettype wire

/* sim/tb_clock_gen.sv */
/*
 * testbench clock and reset, aclrn is released on a falling edge after RESET_CYCLES
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic aclrn
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

    initial begin
        aclrn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);    // release away from the active edge
        aclrn = 1'b1;
    end

endmodule

`default_nettype wire

/* hw/rda_top.sv */
/*
 * read-data alignment stage, memory words and commands arrive as strobes without back-pressure
 * upstream must never have more memory words outstanding than MEM_FIFO_DEPTH
 * upstream may send at most CMD_AF_CUTOFF more commands once o_cmd_almost_full rises
 */
`timescale 1ns/1ps
`default_nettype none

module rda_top import rda_cfg_pkg::*; #(
    parameter  int MEM_BYTES      = DEF_MEM_BYTES,
    parameter  int KER_BYTES      = DEF_KER_BYTES,
    parameter  int ALIGN_BITS     = DEF_ALIGN_BITS,
    parameter  int MEM_FIFO_DEPTH = DEF_MEM_FIFO_DEPTH,
    parameter  int CMD_FIFO_DEPTH = DEF_CMD_FIFO_DEPTH,
    parameter  int OUT_FIFO_DEPTH = DEF_OUT_FIFO_DEPTH,
    localparam int INTRA_W        = $clog2(MEM_BYTES)
) (
    input  wire                    clock,
    input  wire                    aclrn,
    input  wire                    i_mem_valid,
    input  wire  [8*MEM_BYTES-1:0] i_mem_data,
    input  wire                    i_cmd_valid,
    input  wire  [INTRA_W-1:0]     i_cmd_addr,
    output logic                   o_cmd_almost_full,
    output logic                   o_valid,
    output logic [8*KER_BYTES-1:0] o_data,
    input  wire                    i_stall
);

    localparam int SHIFT_W = INTRA_W - ALIGN_BITS;    // one registered stage per shift bit

    // pop to output write is SHIFT_W+2 cycles, plus one for the registered almost-full
    localparam int OUT_AF_CUTOFF = SHIFT_W + 3;

    logic                   mem_empty, mem_pop;
    logic [8*MEM_BYTES-1:0] mem_head;
    logic                   cmd_empty, cmd_pop;
    logic [INTRA_W-1:0]     cmd_head;
    logic                   out_wr, out_empty, out_almost_full;
    logic [8*KER_BYTES-1:0] out_wr_data;

    // element 0 from the sequencer, element SHIFT_W into the assembler
    rda_align_if #(.MEM_BYTES(MEM_BYTES), .INTRA_W(INTRA_W), .SHIFT_W(SHIFT_W))
        beat_if [SHIFT_W+1] ();

    ////////////////////////////////////////////////////////////
    // input buffering
    ////////////////////////////////////////////////////////////
    rda_fifo #(.T(logic [8*MEM_BYTES-1:0]), .DEPTH(MEM_FIFO_DEPTH), .AF_CUTOFF(0)) u_mem_fifo (
        .clock(clock), .aclrn(aclrn),
        .i_wr(i_mem_valid), .i_wr_data(i_mem_data),
        .i_rd(mem_pop), .o_rd_data(mem_head),
        .o_empty(mem_empty), .o_almost_full()    // depth is guaranteed by upstream
    );

    rda_fifo #(.T(logic [INTRA_W-1:0]), .DEPTH(CMD_FIFO_DEPTH), .AF_CUTOFF(CMD_AF_CUTOFF)) u_cmd_fifo (
        .clock(clock), .aclrn(aclrn),
        .i_wr(i_cmd_valid), .i_wr_data(i_cmd_addr),
        .i_rd(cmd_pop), .o_rd_data(cmd_head),
        .o_empty(cmd_empty), .o_almost_full(o_cmd_almost_full)
    );

    ////////////////////////////////////////////////////////////
    // sequencer, rotator stages and assembler
    ////////////////////////////////////////////////////////////
    rda_word_sequencer #(
        .KER_BYTES(KER_BYTES), .MEM_BYTES(MEM_BYTES), .ALIGN_BITS(ALIGN_BITS),
        .INTRA_W(INTRA_W), .SHIFT_W(SHIFT_W)
    ) u_sequencer (
        .clock(clock), .aclrn(aclrn),
        .i_cmd_empty(cmd_empty), .i_cmd_addr(cmd_head), .o_cmd_pop(cmd_pop),
        .i_mem_empty(mem_empty), .i_mem_data(mem_head), .o_mem_pop(mem_pop),
        .i_out_almost_full(out_almost_full),
        .o_beat(beat_if[0])
    );

    for (genvar k = 0; k < SHIFT_W; k++) begin : g_stage
        rda_shift_stage #(
            .STAGE(k), .MEM_BYTES(MEM_BYTES), .INTRA_W(INTRA_W),
            .SHIFT_W(SHIFT_W), .ALIGN_BITS(ALIGN_BITS)
        ) u_stage (
            .clock(clock), .aclrn(aclrn),
            .i_beat(beat_if[k]), .o_beat(beat_if[k+1])
        );
    end

    rda_word_assembler #(
        .KER_BYTES(KER_BYTES), .MEM_BYTES(MEM_BYTES), .INTRA_W(INTRA_W), .SHIFT_W(SHIFT_W)
    ) u_assembler (
        .clock(clock), .aclrn(aclrn),
        .i_beat(beat_if[SHIFT_W]),
        .o_wr(out_wr), .o_wr_data(out_wr_data)
    );

    ////////////////////////////////////////////////////////////
    // output buffering under valid/stall
    ////////////////////////////////////////////////////////////
    rda_fifo #(.T(logic [8*KER_BYTES-1:0]), .DEPTH(OUT_FIFO_DEPTH), .AF_CUTOFF(OUT_AF_CUTOFF)) u_out_fifo (
        .clock(clock), .aclrn(aclrn),
        .i_wr(out_wr), .i_wr_data(out_wr_data),
        .i_rd(o_valid & ~i_stall), .o_rd_data(o_data),    // transfer when valid and not stalled
        .o_empty(out_empty), .o_almost_full(out_almost_full)
    );

    assign o_valid = ~out_empty;

endmodule

`default_nettype wire

/* hw/rda_word_assembler.sv */
/*
 * builds kernel words from aligned beats by byte-enable accumulation
 * a beat only writes kernel bytes at or above its lo_limit, lower bytes are kept
 */
`timescale 1ns/1ps
`default_nettype none

module rda_word_assembler import rda_types_pkg::*; #(
    parameter int KER_BYTES = 4,
    parameter int MEM_BYTES = 8,
    parameter int INTRA_W   = 3,
    parameter int SHIFT_W   = 3
) (
    input  wire                    clock,
    input  wire                    aclrn,
    rda_align_if.dst               i_beat,
    output logic                   o_wr,
    output logic [8*KER_BYTES-1:0] o_wr_data
);

    localparam int GRAN = 2 ** (INTRA_W - SHIFT_W);    // bytes per aligned section

    byte_t [MEM_BYTES-1:0] beat_bytes;
    byte_t [KER_BYTES-1:0] acc_q;      // kernel word under construction
    logic  [KER_BYTES-1:0] byte_en;

    assign beat_bytes = i_beat.data;

    // enables are decided per aligned section, so whole sections switch together
    always_comb begin
        for (int i = 0; i < KER_BYTES; i++) begin
            byte_en[i] = (INTRA_W+1)'(i & ~(GRAN - 1)) >= i_beat.lo_limit;
        end
    end

    always_ff @(posedge clock) begin
        if (i_beat.valid) begin
            for (int i = 0; i < KER_BYTES; i++) begin
                if (byte_en[i]) acc_q[i] <= beat_bytes[i];    // low bytes of the aligned word
            end
        end
    end

    // a head beat leaves the word half built, the tail finishes it
    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) o_wr <= 1'b0;
        else        o_wr <= i_beat.valid && (i_beat.kind != BEAT_HEAD);
    end

    assign o_wr_data = acc_q;

endmodule

`default_nettype wire

/* hw/rda_shift_stage.sv */
/*
 * one registered stage of the wrap-around barrel rotator
 * stage STAGE moves the word toward byte 0 by 2**(STAGE+ALIGN_BITS) bytes when asked
 */
`timescale 1ns/1ps
`default_nettype none

module rda_shift_stage import rda_types_pkg::*; #(
    parameter int STAGE      = 0,
    parameter int MEM_BYTES  = 8,
    parameter int INTRA_W    = 3,
    parameter int SHIFT_W    = 3,
    parameter int ALIGN_BITS = 0
) (
    input  wire      clock,
    input  wire      aclrn,
    rda_align_if.dst i_beat,
    rda_align_if.src o_beat
);

    localparam int AMT = 2 ** (STAGE + ALIGN_BITS);    // bytes moved by this stage

    byte_t [MEM_BYTES-1:0] in_bytes;
    byte_t [MEM_BYTES-1:0] rot_bytes;
    logic  [INTRA_W-1:0]   src_idx;

    assign in_bytes = i_beat.data;

    // the index wraps on its own since MEM_BYTES is 2**INTRA_W
    always_comb begin
        for (int j = 0; j < MEM_BYTES; j++) begin
            src_idx      = INTRA_W'(j + AMT);
            rot_bytes[j] = i_beat.shift[STAGE] ? in_bytes[src_idx] : in_bytes[j];
        end
    end

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) o_beat.valid <= 1'b0;
        else        o_beat.valid <= i_beat.valid;
    end

    always_ff @(posedge clock) begin
        o_beat.data     <= rot_bytes;
        o_beat.shift    <= i_beat.shift & ~(SHIFT_W'(1) << STAGE);    // bit is spent here
        o_beat.lo_limit <= i_beat.lo_limit;
        o_beat.kind     <= i_beat.kind;
    end

endmodule

`default_nettype wire

/* hw/rda_word_sequencer.sv */
/*
 * turns commands and memory words into alignment beats, one memory word per cycle
 * a kernel word may span at most two memory words, so KER_BYTES <= MEM_BYTES
 */
`timescale 1ns/1ps
`default_nettype none

module rda_word_sequencer import rda_types_pkg::*; #(
    parameter int KER_BYTES  = 4,
    parameter int MEM_BYTES  = 8,
    parameter int ALIGN_BITS = 0,
    parameter int INTRA_W    = 3,
    parameter int SHIFT_W    = 3
) (
    input  wire                   clock,
    input  wire                   aclrn,
    input  wire                   i_cmd_empty,
    input  wire [INTRA_W-1:0]     i_cmd_addr,
    output logic                  o_cmd_pop,
    input  wire                   i_mem_empty,
    input  wire [8*MEM_BYTES-1:0] i_mem_data,
    output logic                  o_mem_pop,
    input  wire                   i_out_almost_full,
    rda_align_if.src              o_beat
);

    logic [INTRA_W-1:0] addr_al;      // command address with the known-zero bits forced
    logic [SHIFT_W-1:0] addr_shift;   // rotation in units of the address alignment
    logic               spans_two;    // kernel word runs into the next memory word
    logic               beat_go;      // one memory word is consumed this cycle
    logic               at_second;    // head beat issued, the tail beat is next

    assign addr_al    = i_cmd_addr & ~INTRA_W'((1 << ALIGN_BITS) - 1);
    assign addr_shift = addr_al[INTRA_W-1:ALIGN_BITS];
    assign spans_two  = ({1'b0, addr_al} + (INTRA_W+1)'(KER_BYTES)) > (INTRA_W+1)'(MEM_BYTES);

    // the output FIFO almost-full already counts every beat that is still in flight
    assign beat_go   = ~i_cmd_empty & ~i_mem_empty & ~i_out_almost_full;
    assign o_mem_pop = beat_go;
    assign o_cmd_pop = beat_go & (~spans_two | at_second);    // done after sole or tail

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            at_second    <= 1'b0;
            o_beat.valid <= 1'b0;
        end else begin
            o_beat.valid <= beat_go;
            if (beat_go) at_second <= spans_two & ~at_second;
        end
    end

    ////////////////////////////////////////////////////////////
    // beat payload, registered one cycle after the pop
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        o_beat.data  <= i_mem_data;
        o_beat.shift <= addr_shift;    // both beats of a word rotate by the same amount
        if (at_second) begin
            // head already filled the kernel bytes below this point
            o_beat.lo_limit <= (INTRA_W+1)'(MEM_BYTES) - {1'b0, addr_al};
            o_beat.kind     <= BEAT_TAIL;
        end else begin
            o_beat.lo_limit <= '0;
            o_beat.kind     <= spans_two ? BEAT_HEAD : BEAT_SOLE;
        end
    end

endmodule

`default_nettype wire

/* hw/rda_fifo.sv */
/*
 * show-ahead FIFO, the head entry is always on o_rd_data while o_empty is low
 * writes when full and reads when empty are not guarded, the user must avoid them
 */
`timescale 1ns/1ps
`default_nettype none

module rda_fifo #(
    parameter type T         = logic [7:0],
    parameter int  DEPTH     = 16,
    parameter int  AF_CUTOFF = 2
) (
    input  wire  clock,
    input  wire  aclrn,
    input  wire  i_wr,
    input  var T i_wr_data,
    input  wire  i_rd,
    output T     o_rd_data,
    output logic o_empty,
    output logic o_almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);    // must hold DEPTH itself

    T                 mem [DEPTH];    // storage, no reset needed
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;          // entries currently held

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (i_wr) mem[wr_ptr] <= i_wr_data;
    end

    always_ff @(posedge clock or negedge aclrn) begin
        if (!aclrn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) wr_ptr <= next_ptr(wr_ptr);
            if (i_rd) rd_ptr <= next_ptr(rd_ptr);
            case ({i_wr, i_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither leaves occupancy alone
            endcase
        end
    end

    assign o_rd_data     = mem[rd_ptr];                          // a write shows here next cycle
    assign o_empty       = (count == '0);
    assign o_almost_full = ((DEPTH - int'(count)) <= AF_CUTOFF);  // free entries at or below cutoff

endmodule

`default_nettype wire

/* hw/rda_align_if.sv */
/*
 * one alignment beat between pipeline modules, valid is a single-cycle strobe
 * there is no back-pressure so the receiver must take every beat
 */
`timescale 1ns/1ps
`default_nettype none

interface rda_align_if import rda_types_pkg::*; #(
    parameter int MEM_BYTES = 8,
    parameter int INTRA_W   = 3,
    parameter int SHIFT_W   = 3
);

    logic                   valid;       // one beat this cycle
    logic [8*MEM_BYTES-1:0] data;        // memory word, rotated further at each stage
    logic [SHIFT_W-1:0]     shift;       // rotation still owed, in aligned sections
    logic [INTRA_W:0]       lo_limit;    // lowest kernel byte this beat may write
    beat_e                  kind;

    // the producing side of a link
    modport src (output valid, output data, output shift, output lo_limit, output kind);

    // the consuming side of a link
    modport dst (input valid, input data, input shift, input lo_limit, input kind);

endinterface

`default_nettype wire

/* hw/rda_types_pkg.sv */
/*
 * beat kinds and the byte type that travel down the alignment pipeline
 */
`default_nettype none

package rda_types_pkg;

    // a kernel word takes either one beat (sole) or two beats (head then tail)
    typedef enum logic [1:0] {
        BEAT_SOLE = 2'd0,    // kernel word lies inside one memory word
        BEAT_HEAD = 2'd1,    // first memory word of a split kernel word
        BEAT_TAIL = 2'd2     // second memory word, completes the kernel word
    } beat_e;

    typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

/* hw/rda_cfg_pkg.sv */
/*
 * default sizes for the read-data alignment stage and the widths derived from them
 * the memory word width must be a power of two and no narrower than a kernel word
 */
`default_nettype none

package rda_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths in bytes
    ////////////////////////////////////////////////////////////
    localparam int DEF_MEM_BYTES  = 8;    // memory word, power of two
    localparam int DEF_KER_BYTES  = 4;    // kernel word, at most DEF_MEM_BYTES
    localparam int DEF_ALIGN_BITS = 0;    // low address bits known to be zero

    // derived widths, the same arithmetic the top level does on its parameters
    localparam int DEF_INTRA_W = $clog2(DEF_MEM_BYTES);
    localparam int DEF_SHIFT_W = DEF_INTRA_W - DEF_ALIGN_BITS;

    ////////////////////////////////////////////////////////////
    // buffering
    ////////////////////////////////////////////////////////////
    localparam int DEF_MEM_FIFO_DEPTH = 32;    // upstream keeps no more than this outstanding
    localparam int DEF_CMD_FIFO_DEPTH = 16;
    localparam int DEF_OUT_FIFO_DEPTH = 16;
    localparam int CMD_AF_CUTOFF      = 2;     // commands upstream may still send after almost-full

endpackage

`default_nettype wire
